// ==== sim.f ====
rtl/tile_load_pkg.sv
rtl/load_trans_if.sv
rtl/in_fm_tile_ctrl.sv
rtl/rmst_burst_issuer.sv
rtl/rmst_word_unpacker.sv
rtl/in_fm_filter.sv
rtl/rmst_to_in_fm_fifo_tile.sv
sim/avalon_rmst_model.sv
sim/tile_load_asserts.sv
sim/tb_tile_load.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_tile_load -f sim.f \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_tile_load > sim.log 2>&1
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// ==== sim/tb_tile_load.sv ====
// Testbench for the tile loader; runs tile loads against a read master model and checks every push
`timescale 1ns/1ps
`default_nettype none

module tb_tile_load #(
    parameter int N  = 4,
    parameter int R  = 8,
    parameter int C  = 16,
    parameter int Tn = 2,
    parameter int Tr = 4,
    parameter int Tc = 6
);
    import tile_load_pkg::*;

    localparam logic [31:0] seed_init = 32'ha6d0_aa3a;
    localparam int          num_loads = 5;
    // Each row needs far fewer than 500 cycles even with full delays and back-pressure
    localparam int          timeout_cycles = num_loads * Tn * Tr * 500;

    logic  clk;
    logic  rst;
    logic  load_start;
    cnt_t  tile_base_m;
    cnt_t  tile_base_row;
    cnt_t  tile_base_col;
    logic  load_fifo_almost_full = 1'b0;
    logic  load_done;
    logic  load_fifo_push;
    word_t rmst_load_data;
    logic  rmst_go;
    logic  rmst_done;
    logic  rmst_fixed_location;
    addr_t rmst_read_base;
    addr_t rmst_read_length;
    logic  rmst_user_read_buffer;
    beat_t rmst_user_buffer_data;
    logic  rmst_user_data_available;

    word_t       exp_q[$];
    word_t       exp_word;
    logic        af_random;
    logic [31:0] rnd;
    integer      seed;
    int          cycles = 0;
    int          push_total = 0;
    int          done_total = 0;
    int          mismatches = 0;
    int          task_errors;
    int          asserts_failed;
    int          loads_started;
    int          tests_failed;

    rmst_to_in_fm_fifo_tile #(
        .N  (N),
        .R  (R),
        .C  (C),
        .Tn (Tn),
        .Tr (Tr),
        .Tc (Tc)
    ) i_dut (
        .clk                      (clk),
        .rst                      (rst),
        .rmst_fixed_location      (rmst_fixed_location),
        .rmst_read_base           (rmst_read_base),
        .rmst_read_length         (rmst_read_length),
        .rmst_go                  (rmst_go),
        .rmst_done                (rmst_done),
        .rmst_user_read_buffer    (rmst_user_read_buffer),
        .rmst_user_buffer_data    (rmst_user_buffer_data),
        .rmst_user_data_available (rmst_user_data_available),
        .rmst_load_data           (rmst_load_data),
        .load_fifo_push           (load_fifo_push),
        .load_fifo_almost_full    (load_fifo_almost_full),
        .load_start               (load_start),
        .tile_base_m              (tile_base_m),
        .tile_base_row            (tile_base_row),
        .tile_base_col            (tile_base_col),
        .load_done                (load_done)
    );

    avalon_rmst_model #(
        .mem_words  (N * R * C),
        .delay_seed (seed_init)
    ) i_rmst (
        .clk                      (clk),
        .rst                      (rst),
        .rmst_go                  (rmst_go),
        .rmst_read_base           (rmst_read_base),
        .rmst_read_length         (rmst_read_length),
        .rmst_fixed_location      (rmst_fixed_location),
        .rmst_done                (rmst_done),
        .rmst_user_buffer_data    (rmst_user_buffer_data),
        .rmst_user_data_available (rmst_user_data_available),
        .rmst_user_read_buffer    (rmst_user_read_buffer)
    );

    bind rmst_to_in_fm_fifo_tile tile_load_asserts i_asserts (
        .clk                   (clk),
        .rst                   (rst),
        .rmst_go               (rmst_go),
        .rmst_read_base        (rmst_read_base),
        .rmst_read_length      (rmst_read_length),
        .rmst_done             (rmst_done),
        .rmst_user_read_buffer (rmst_user_read_buffer),
        .load_fifo_push        (load_fifo_push),
        .rmst_load_data        (rmst_load_data),
        .load_fifo_almost_full (load_fifo_almost_full),
        .load_done             (load_done),
        .row_start             (trans.start)
    );

    always #20 clk = ~clk;

    // Word index of tile element (ch, r, c) in the row-major map
    function automatic int tile_word_index(input cnt_t m, input cnt_t row, input cnt_t col,
                                           input int ch, input int r, input int c);
        return (int'(m) + ch) * R * C + (int'(row) + r) * C + int'(col) + c;
    endfunction

    // Random back-pressure, drawn every cycle so the sequence stays fixed
    always @(posedge clk) begin
        rnd = $random(seed);
        if (af_random) begin
            load_fifo_almost_full <= rnd[0];
        end else begin
            load_fifo_almost_full <= 1'b0;
        end
    end

    // Push checker against the expected word queue
    always @(posedge clk) begin
        if (!rst && load_fifo_push) begin
            push_total = push_total + 1;
            assert (exp_q.size() > 0) else begin
                mismatches = mismatches + 1;
                $display("Push at %0t ns with no tile word left to load", $time);
            end
            if (exp_q.size() > 0) begin
                exp_word = exp_q.pop_front();
                assert (rmst_load_data == exp_word) else begin
                    mismatches = mismatches + 1;
                    $display("MISMATCH at %0t ns: pushed word expected %0d, got %0d",
                             $time, exp_word, rmst_load_data);
                end
            end
        end
        if (!rst && load_done) begin
            done_total = done_total + 1;
        end
    end

    // Run limit in clock cycles
    initial begin
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("Timeout: the loads did not finish within %0d cycles", timeout_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic run_load(input string name, input cnt_t m, input cnt_t row, input cnt_t col,
                            input logic random_af);
        int ch;
        int r;
        int c;
        int words;
        int push_before;
        int mism_before;
        int bad;
        exp_q.delete();
        for (ch = 0; ch < Tn; ch++) begin
            for (r = 0; r < Tr; r++) begin
                for (c = 0; c < Tc; c++) begin
                    exp_q.push_back(word_t'(tile_word_index(m, row, col, ch, r, c)));
                end
            end
        end
        words       = exp_q.size();
        push_before = push_total;
        mism_before = mismatches;
        bad         = 0;
        @(posedge clk);
        af_random     <= random_af;
        load_start    <= 1'b1;
        tile_base_m   <= m;
        tile_base_row <= row;
        tile_base_col <= col;
        loads_started = loads_started + 1;
        @(posedge clk);
        load_start <= 1'b0;
        do begin
            @(posedge clk);
        end while (!load_done);
        af_random <= 1'b0;
        assert (push_total - push_before == words) else begin
            bad = bad + 1;
            $display("MISMATCH at %0t ns: %s pushed %0d words, expected %0d",
                     $time, name, push_total - push_before, words);
        end
        assert (exp_q.size() == 0) else begin
            bad = bad + 1;
            $display("Load %s finished with %0d tile words never pushed", name, exp_q.size());
        end
        task_errors = task_errors + bad;
        if (bad == 0 && mismatches == mism_before) begin
            $display("%-32s ok, %0d words", name, words);
        end else begin
            tests_failed = tests_failed + 1;
            $display("%-32s failed", name);
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        load_start    = 1'b0;
        tile_base_m   = '0;
        tile_base_row = '0;
        tile_base_col = '0;
        af_random     = 1'b0;
        seed          = seed_init;
        task_errors   = 0;
        loads_started = 0;
        tests_failed  = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        run_load("aligned tile (0,0,0)", 16'd0, 16'd0, 16'd0, 1'b0);
        run_load("unaligned tile (1,2,3)", 16'd1, 16'd2, 16'd3, 1'b0);
        run_load("back-pressure tile (2,4,10)", 16'd2, 16'd4, 16'd10, 1'b1);
        run_load("back-pressure tile (0,1,7)", 16'd0, 16'd1, 16'd7, 1'b1);
        run_load("back-pressure tile (2,3,9)", 16'd2, 16'd3, 16'd9, 1'b1);

        // Idle cycles to expose stray pushes or extra done pulses
        repeat (4) @(posedge clk);
        assert (done_total == loads_started) else begin
            task_errors = task_errors + 1;
            $display("MISMATCH at %0t ns: load_done pulsed %0d times for %0d loads",
                     $time, done_total, loads_started);
        end
        asserts_failed = i_dut.i_asserts.failures;

        $display("Summary: %0d loads, %0d failed, %0d words checked, %0d errors",
                 loads_started, tests_failed, push_total,
                 mismatches + task_errors + asserts_failed);
        if (tests_failed == 0 && mismatches + task_errors + asserts_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tile_load_asserts.sv ====
// Concurrent checks on the tile loader top; bound to the DUT from the testbench
`timescale 1ns/1ps
`default_nettype none

module tile_load_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 rmst_go,
    input tile_load_pkg::addr_t rmst_read_base,
    input tile_load_pkg::addr_t rmst_read_length,
    input logic                 rmst_done,
    input logic                 rmst_user_read_buffer,
    input logic                 load_fifo_push,
    input tile_load_pkg::word_t rmst_load_data,
    input logic                 load_fifo_almost_full,
    input logic                 load_done,
    input logic                 row_start
);
    import tile_load_pkg::*;

    // Words requested from the read master and not yet popped
    addr_t outst_words;

    // Failed assertion count
    int failures = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outst_words <= '0;
        end else begin
            outst_words <= outst_words
                         + (rmst_go ? (rmst_read_length >> 2) : addr_t'(0))
                         - (rmst_user_read_buffer ? addr_t'(wcnt) : addr_t'(0));
        end
    end

    a_go_aligned: assert property (@(posedge clk) disable iff (rst)
        rmst_go |-> (rmst_read_base[3:0] == 4'h0))
        else begin
            failures++;
            $error("burst base address is not beat aligned");
        end

    a_go_length: assert property (@(posedge clk) disable iff (rst)
        rmst_go |-> (rmst_read_length != '0) && (rmst_read_length <= addr_t'(blen * 16)))
        else begin
            failures++;
            $error("burst length is zero or longer than the burst limit");
        end

    a_go_when_done: assert property (@(posedge clk) disable iff (rst)
        rmst_go |-> rmst_done)
        else begin
            failures++;
            $error("burst issued while the read master is busy");
        end

    a_go_spacing: assert property (@(posedge clk) disable iff (rst)
        rmst_go |=> !rmst_go)
        else begin
            failures++;
            $error("two bursts issued in back-to-back cycles");
        end

    a_capacity: assert property (@(posedge clk) disable iff (rst)
        outst_words <= addr_t'(rmst_capacity))
        else begin
            failures++;
            $error("outstanding words exceed the read master buffer");
        end

    a_push_known: assert property (@(posedge clk) disable iff (rst)
        load_fifo_push |-> !$isunknown(rmst_load_data))
        else begin
            failures++;
            $error("pushed word has unknown bits");
        end

    a_row_backpressure: assert property (@(posedge clk) disable iff (rst)
        row_start |-> !load_fifo_almost_full)
        else begin
            failures++;
            $error("row transfer started while the FIFO is almost full");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        load_done |=> !load_done)
        else begin
            failures++;
            $error("load_done is longer than one cycle");
        end

    a_done_after_push: assert property (@(posedge clk) disable iff (rst)
        load_done |-> !load_fifo_push)
        else begin
            failures++;
            $error("load_done coincides with a push");
        end

    // Quiet outputs during reset and the cycle after it
    a_reset_quiet: assert property (@(posedge clk)
        (rst || $past(rst)) |-> !(rmst_go || rmst_user_read_buffer || load_fifo_push || load_done))
        else begin
            failures++;
            $error("DUT output active around reset");
        end

endmodule

`default_nettype wire

// ==== sim/avalon_rmst_model.sv ====
// Behavioural Avalon-style read master for the tile loader testbench; memory words hold their index
`timescale 1ns/1ps
`default_nettype none

module avalon_rmst_model #(
    parameter int          mem_words  = 512,
    parameter logic [31:0] delay_seed = 32'h1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rmst_go,
    input  tile_load_pkg::addr_t rmst_read_base,
    input  tile_load_pkg::addr_t rmst_read_length,
    input  logic                 rmst_fixed_location,
    output logic                 rmst_done,
    output tile_load_pkg::beat_t rmst_user_buffer_data,
    output logic                 rmst_user_data_available,
    input  logic                 rmst_user_read_buffer
);
    import tile_load_pkg::*;

    localparam int buf_beats = rmst_capacity / wcnt;

    word_t  mem [mem_words];
    beat_t  fifo_mem [buf_beats];
    int     wr_ptr;
    int     rd_ptr;
    int     fill;
    int     next_word;
    int     beats_left;
    int     delay;
    int     fill_idx;
    integer seed;
    logic   beat_push;

    // Each word carries its own word index
    initial begin
        seed = delay_seed;
        for (fill_idx = 0; fill_idx < mem_words; fill_idx++) begin
            mem[fill_idx] = word_t'(fill_idx);
        end
    end

    function automatic beat_t beat_at(input int w);
        beat_t b;
        for (int k = 0; k < wcnt; k++) begin
            b[k*dw +: dw] = mem[w + k];
        end
        return b;
    endfunction

    // One beat per cycle once the burst delay has run out
    assign beat_push = (beats_left != 0) && (delay <= 1);

    assign rmst_user_data_available = (fill != 0);
    assign rmst_user_buffer_data    = fifo_mem[rd_ptr];

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rmst_done  <= 1'b1;
            next_word  <= 0;
            beats_left <= 0;
            delay      <= 0;
            wr_ptr     <= 0;
            rd_ptr     <= 0;
            fill       <= 0;
        end else begin
            if (rmst_go) begin
                rmst_done  <= 1'b0;
                next_word  <= int'(rmst_read_base >> 2);
                beats_left <= int'(rmst_read_length >> 4);
                delay      <= 1 + int'({$random(seed)} % 32'd4);
            end else if (beat_push) begin
                // A fixed location burst rereads the same beat
                next_word  <= rmst_fixed_location ? next_word : next_word + wcnt;
                beats_left <= beats_left - 1;
                rmst_done  <= (beats_left == 1);
                wr_ptr     <= (wr_ptr + 1) % buf_beats;
            end else if (beats_left != 0) begin
                delay <= delay - 1;
            end
            if (rmst_user_read_buffer) begin
                rd_ptr <= (rd_ptr + 1) % buf_beats;
            end
            fill <= fill + int'(beat_push) - int'(rmst_user_read_buffer);
        end
    end

    always @(posedge clk) begin
        if (beat_push) begin
            fifo_mem[wr_ptr] <= beat_at(next_word);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rmst_to_in_fm_fifo_tile.sv ====
// Input feature map tile loader top; wires the controller, issuer, unpacker and filter together
`timescale 1ns/1ps
`default_nettype none

module rmst_to_in_fm_fifo_tile #(
    parameter int N  = 4,
    parameter int R  = 8,
    parameter int C  = 16,
    parameter int Tn = 2,
    parameter int Tr = 4,
    parameter int Tc = 6
) (
    input  logic                 clk,
    input  logic                 rst,
    // Read master
    output logic                 rmst_fixed_location,
    output tile_load_pkg::addr_t rmst_read_base,
    output tile_load_pkg::addr_t rmst_read_length,
    output logic                 rmst_go,
    input  logic                 rmst_done,
    output logic                 rmst_user_read_buffer,
    input  tile_load_pkg::beat_t rmst_user_buffer_data,
    input  logic                 rmst_user_data_available,
    // Load FIFO
    output tile_load_pkg::word_t rmst_load_data,
    output logic                 load_fifo_push,
    input  logic                 load_fifo_almost_full,
    // Tile request
    input  logic                 load_start,
    input  tile_load_pkg::cnt_t  tile_base_m,
    input  tile_load_pkg::cnt_t  tile_base_row,
    input  tile_load_pkg::cnt_t  tile_base_col,
    output logic                 load_done
);
    import tile_load_pkg::*;

    word_t word;
    logic  word_valid;

    load_trans_if trans ();

    in_fm_tile_ctrl #(
        .N  (N),
        .R  (R),
        .C  (C),
        .Tn (Tn),
        .Tr (Tr),
        .Tc (Tc)
    ) i_ctrl (
        .clk                   (clk),
        .rst                   (rst),
        .load_start            (load_start),
        .tile_base_m           (tile_base_m),
        .tile_base_row         (tile_base_row),
        .tile_base_col         (tile_base_col),
        .load_fifo_almost_full (load_fifo_almost_full),
        .load_done             (load_done),
        .trans                 (trans.ctrl)
    );

    rmst_burst_issuer i_issuer (
        .clk                   (clk),
        .rst                   (rst),
        .trans                 (trans.issuer),
        .rmst_go               (rmst_go),
        .rmst_read_base        (rmst_read_base),
        .rmst_read_length      (rmst_read_length),
        .rmst_done             (rmst_done),
        .rmst_user_read_buffer (rmst_user_read_buffer),
        .rmst_fixed_location   (rmst_fixed_location)
    );

    rmst_word_unpacker i_unpacker (
        .clk                      (clk),
        .rst                      (rst),
        .trans                    (trans.unpacker),
        .rmst_user_buffer_data    (rmst_user_buffer_data),
        .rmst_user_data_available (rmst_user_data_available),
        .rmst_user_read_buffer    (rmst_user_read_buffer),
        .word                     (word),
        .word_valid               (word_valid)
    );

    in_fm_filter i_filter (
        .clk            (clk),
        .rst            (rst),
        .trans          (trans.filter),
        .word           (word),
        .word_valid     (word_valid),
        .rmst_load_data (rmst_load_data),
        .load_fifo_push (load_fifo_push)
    );

endmodule

`default_nettype wire

// ==== rtl/in_fm_filter.sv ====
// Keeps only the tile columns of a row span and pushes them into the load FIFO
`timescale 1ns/1ps
`default_nettype none

module in_fm_filter (
    input  logic                 clk,
    input  logic                 rst,
    load_trans_if.filter         trans,
    input  tile_load_pkg::word_t word,
    input  logic                 word_valid,
    output tile_load_pkg::word_t rmst_load_data,
    output logic                 load_fifo_push
);
    import tile_load_pkg::*;

    cnt_t  idx;
    cnt_t  lo;
    cnt_t  hi;
    logic  in_win;
    word_t data_q;

    // Tile columns sit at [lead, lead + keep) within the span
    assign lo     = cnt_t'(trans.lead);
    assign hi     = lo + trans.keep;
    assign in_win = (idx >= lo) && (idx < hi);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx            <= '0;
            load_fifo_push <= 1'b0;
        end else begin
            load_fifo_push <= word_valid && in_win;
            if (trans.start) begin
                idx <= '0;
            end else if (word_valid) begin
                idx <= idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid) begin
            data_q <= word;
        end
    end

    assign rmst_load_data = data_q;

endmodule

`default_nettype wire

// ==== rtl/rmst_word_unpacker.sv ====
// Pops read master beats and emits their 32-bit words lowest first, flagging the end of a row
`timescale 1ns/1ps
`default_nettype none

module rmst_word_unpacker (
    input  logic                 clk,
    input  logic                 rst,
    load_trans_if.unpacker       trans,
    input  tile_load_pkg::beat_t rmst_user_buffer_data,
    input  logic                 rmst_user_data_available,
    output logic                 rmst_user_read_buffer,
    output tile_load_pkg::word_t word,
    output logic                 word_valid
);
    import tile_load_pkg::*;

    logic [wcnt-1:0] word_ena;
    beat_t           shreg;
    cnt_t            beats_left;
    logic            done_q;

    // Pop when idle or while the last word of the current beat goes out
    assign rmst_user_read_buffer = rmst_user_data_available && (beats_left != '0)
                                 && ((word_ena == '0) || word_ena[wcnt-1]);

    assign word       = shreg[dw-1:0];
    assign word_valid = |word_ena;
    assign trans.done = done_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word_ena   <= '0;
            beats_left <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= word_ena[wcnt-1] && (beats_left == '0);
            if (trans.start) begin
                beats_left <= trans.nbeats;
            end else if (rmst_user_read_buffer) begin
                beats_left <= beats_left - 1'b1;
            end
            if (rmst_user_read_buffer) begin
                word_ena <= {{(wcnt-1){1'b0}}, 1'b1};
            end else begin
                word_ena <= word_ena << 1;
            end
        end
    end

    // Beat payload, shifted down one word per cycle
    always_ff @(posedge clk) begin
        if (rmst_user_read_buffer) begin
            shreg <= rmst_user_buffer_data;
        end else if (word_valid) begin
            shreg <= shreg >> dw;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rmst_burst_issuer.sv ====
// Cuts a row transfer into read master bursts without overrunning the read master buffer
`timescale 1ns/1ps
`default_nettype none

module rmst_burst_issuer (
    input  logic                 clk,
    input  logic                 rst,
    load_trans_if.issuer         trans,
    output logic                 rmst_go,
    output tile_load_pkg::addr_t rmst_read_base,
    output tile_load_pkg::addr_t rmst_read_length,
    input  logic                 rmst_done,
    input  logic                 rmst_user_read_buffer,
    output logic                 rmst_fixed_location
);
    import tile_load_pkg::*;

    cnt_t  rem;
    addr_t next_addr;
    cnt_t  burst_beats;
    cnt_t  burst_words;
    cnt_t  outst;
    logic  go_q;
    logic  room;

    // Burst size for the next go
    assign burst_beats = (rem > cnt_t'(blen)) ? cnt_t'(blen) : rem;
    assign burst_words = burst_beats << 2;

    // Words requested but not yet popped must fit in the buffer
    assign room = (outst + burst_words) <= cnt_t'(rmst_capacity);

    assign rmst_go = (rem != '0) && rmst_done && !go_q && room;

    assign rmst_read_base      = next_addr;
    assign rmst_read_length    = addr_t'(burst_beats) << 4;
    assign rmst_fixed_location = 1'b0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rem       <= '0;
            next_addr <= '0;
            go_q      <= 1'b0;
        end else begin
            go_q <= rmst_go;
            if (trans.start) begin
                rem       <= trans.nbeats;
                next_addr <= trans.raddr;
            end else if (rmst_go) begin
                rem       <= rem - burst_beats;
                next_addr <= next_addr + (addr_t'(burst_beats) << 4);
            end
        end
    end

    // Outstanding word count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outst <= '0;
        end else begin
            case ({rmst_go, rmst_user_read_buffer})
                2'b10: outst <= outst + burst_words;
                2'b01: outst <= outst - cnt_t'(wcnt);
                2'b11: outst <= outst + burst_words - cnt_t'(wcnt);
                default: outst <= outst;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/in_fm_tile_ctrl.sv ====
// Tile load sequencer; steps channels and rows and hands one aligned row transfer at a time
`timescale 1ns/1ps
`default_nettype none

module in_fm_tile_ctrl #(
    parameter int N  = 4,
    parameter int R  = 8,
    parameter int C  = 16,
    parameter int Tn = 2,
    parameter int Tr = 4,
    parameter int Tc = 6
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_start,
    input  tile_load_pkg::cnt_t tile_base_m,
    input  tile_load_pkg::cnt_t tile_base_row,
    input  tile_load_pkg::cnt_t tile_base_col,
    input  logic                load_fifo_almost_full,
    output logic                load_done,
    load_trans_if.ctrl          trans
);
    import tile_load_pkg::*;

    localparam addr_t plane_words = addr_t'(R * C);
    localparam int    beat_shift  = $clog2(wcnt);

    typedef enum logic [1:0] {
        st_idle,
        st_check,
        st_busy,
        st_fin
    } state_t;

    state_t state;
    cnt_t   base_m;
    cnt_t   base_row;
    cnt_t   base_col;
    cnt_t   ch;
    cnt_t   row;
    addr_t  first;
    cnt_t   span;
    logic   last_row;

    // A tile larger than the map cannot be walked
    if (Tn > N || Tr > R || Tc > C) begin : g_tile_check
        $error("tile does not fit inside the feature map");
    end

    // Word index of the first tile word in this row
    always_comb begin
        first = (addr_t'(base_m) + addr_t'(ch)) * plane_words
              + (addr_t'(base_row) + addr_t'(row)) * addr_t'(C)
              + addr_t'(base_col);
        span  = cnt_t'(first[1:0]) + cnt_t'(Tc) + cnt_t'(wcnt - 1);
    end

    assign last_row = (ch == cnt_t'(Tn - 1)) && (row == cnt_t'(Tr - 1));

    // Row span rounded out to whole beats
    assign trans.raddr  = {first[xaw-3:2], 4'b0000};
    assign trans.lead   = first[1:0];
    assign trans.nbeats = span >> beat_shift;
    assign trans.keep   = cnt_t'(Tc);

    // FIFO room is checked only here, before the row begins
    assign trans.start = (state == st_check) && !load_fifo_almost_full;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            base_m    <= '0;
            base_row  <= '0;
            base_col  <= '0;
            ch        <= '0;
            row       <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= (state == st_fin);
            case (state)
                st_idle: begin
                    if (load_start) begin
                        base_m   <= tile_base_m;
                        base_row <= tile_base_row;
                        base_col <= tile_base_col;
                        ch       <= '0;
                        row      <= '0;
                        state    <= st_check;
                    end
                end
                st_check: begin
                    if (!load_fifo_almost_full) begin
                        state <= st_busy;
                    end
                end
                st_busy: begin
                    if (trans.done) begin
                        if (last_row) begin
                            state <= st_fin;
                        end else if (row == cnt_t'(Tr - 1)) begin
                            row   <= '0;
                            ch    <= ch + 1'b1;
                            state <= st_check;
                        end else begin
                            row   <= row + 1'b1;
                            state <= st_check;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/load_trans_if.sv ====
// One row transfer handed from the tile controller to the burst issuer, unpacker and filter
`timescale 1ns/1ps
`default_nettype none

interface load_trans_if;
    import tile_load_pkg::*;

    logic       start;
    addr_t      raddr;
    cnt_t       nbeats;
    logic [1:0] lead;
    cnt_t       keep;
    logic       done;

    modport ctrl (output start, output raddr, output nbeats, output lead, output keep,
                  input done);
    modport issuer (input start, input raddr, input nbeats);
    modport unpacker (input start, input nbeats, output done);
    modport filter (input start, input lead, input keep);

endinterface

`default_nettype wire

// ==== rtl/tile_load_pkg.sv ====
// Shared widths, burst limits and types for the feature map tile loader; imported by each RTL file
`default_nettype none

package tile_load_pkg;

    // Feature map word and read master beat widths
    localparam int dw  = 32;
    localparam int xdw = 128;

    // Byte address width on the read master
    localparam int xaw = 32;

    // Words carried by one beat
    localparam int wcnt = xdw / dw;

    // Longest burst in beats
    localparam int blen = 8;

    // Read master beat buffer size in words
    localparam int rmst_capacity = 64;

    typedef logic [dw-1:0]  word_t;
    typedef logic [xdw-1:0] beat_t;
    typedef logic [xaw-1:0] addr_t;

    // Word or beat counts inside one load
    typedef logic [15:0]    cnt_t;

endpackage

`default_nettype wire
